// ==== common/mshr_pkg.sv ====
`default_nettype none

package mshr_pkg;

  // queue geometry
  localparam int mshr_depth       = 8;
  localparam int num_miss_ports   = 2;
  localparam int num_search_ports = 2;

  // byte address minus the 3-bit block offset
  localparam int line_addr_width = 29;
  localparam int block_width     = 64;
  localparam int mem_tag_width   = 4;

  typedef logic [$clog2(mshr_depth)-1:0]   mshr_idx_t;
  typedef logic [$clog2(mshr_depth+1)-1:0] mshr_count_t;
  typedef logic [line_addr_width-1:0]      line_addr_t;
  typedef logic [block_width-1:0]          block_t;

  // tag 0 means no transaction
  typedef logic [mem_tag_width-1:0] mem_tag_t;

  typedef enum logic [1:0] {
    bus_none  = 2'h0,
    bus_load  = 2'h1,
    bus_store = 2'h2
  } bus_cmd_e;

  // waiting until memory accepts the request
  // in_progress while a load waits for its tagged reply
  // done once the data is final and the entry may retire
  typedef enum logic [1:0] {
    waiting     = 2'h0,
    in_progress = 2'h1,
    done        = 2'h2
  } entry_state_e;

  typedef struct packed {
    logic       valid;
    bus_cmd_e   cmd;
    line_addr_t addr;
    block_t     data;
  } miss_req_t;

  // line handed back to the cache
  typedef struct packed {
    line_addr_t addr;
    block_t     data;
  } fill_t;

  typedef struct packed {
    logic         valid;
    entry_state_e state;
    bus_cmd_e     cmd;
    line_addr_t   addr;
    block_t       data;
    mem_tag_t     mem_tag;
  } mshr_entry_t;

endpackage

`default_nettype wire

// ==== mshr/mshr_alloc_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module mshr_alloc_select (
  input  mshr_pkg::miss_req_t [mshr_pkg::num_miss_ports-1:0] miss,
  output mshr_pkg::miss_req_t [mshr_pkg::num_miss_ports-1:0] slot_req,
  output logic [1:0]                                         alloc_count
);

  import mshr_pkg::*;

  // each slot takes the lowest active port not claimed by an earlier slot
  always_comb begin
    logic [num_miss_ports-1:0] pending;
    logic [1:0]                count;
    logic                      found;
    int                        pick;

    for (int p = 0; p < num_miss_ports; p++) begin
      pending[p] = miss[p].valid;
    end
    count = '0;

    for (int s = 0; s < num_miss_ports; s++) begin
      found = 1'b0;
      pick  = 0;
      // downward scan so the lowest set bit wins
      for (int p = num_miss_ports - 1; p >= 0; p--) begin
        if (pending[p]) begin
          found = 1'b1;
          pick  = p;
        end
      end

      slot_req[s] = '0;
      if (found) begin
        slot_req[s]   = miss[pick];
        pending[pick] = 1'b0;
        count         = count + 2'd1;
      end
    end

    alloc_count = count;
  end

endmodule

`default_nettype wire

// ==== mshr/mshr_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module mshr_queue (
  input  logic                                               clock,
  input  logic                                               reset,
  input  mshr_pkg::miss_req_t [mshr_pkg::num_miss_ports-1:0] slot_req,
  input  logic [1:0]                                         alloc_count,
  output logic                                               full,
  output mshr_pkg::bus_cmd_e                                 proc2mem_command,
  output mshr_pkg::line_addr_t                               proc2mem_addr,
  output mshr_pkg::block_t                                   proc2mem_data,
  input  mshr_pkg::mem_tag_t                                 mem2proc_response,
  input  mshr_pkg::mem_tag_t                                 mem2proc_tag,
  input  mshr_pkg::block_t                                   mem2proc_data,
  output logic                                               fill_valid,
  output mshr_pkg::fill_t                                    fill,
  input  logic                                               stored,
  output mshr_pkg::mshr_entry_t [mshr_pkg::mshr_depth-1:0]   entries
);

  import mshr_pkg::*;

  mshr_entry_t [mshr_depth-1:0] queue;

  // tail allocates, head issues, wb_head retires
  mshr_idx_t tail;
  mshr_idx_t head;
  mshr_idx_t wb_head;

  mshr_idx_t [num_miss_ports-1:0] alloc_idx;
  mshr_count_t                    valid_count;
  mshr_entry_t                    head_entry;
  mshr_entry_t                    wb_entry;

  logic issue_ready;
  logic accept;
  logic do_alloc;
  logic store_retire;
  logic retire;

  always_comb begin
    valid_count = '0;
    for (int i = 0; i < mshr_depth; i++) begin
      valid_count = valid_count + mshr_count_t'(queue[i].valid);
    end
  end

  // room must remain for a full cycle of misses
  assign full     = valid_count > mshr_count_t'(mshr_depth - num_miss_ports);
  assign do_alloc = !full && (alloc_count != '0);

  always_comb begin
    for (int s = 0; s < num_miss_ports; s++) begin
      alloc_idx[s] = tail + mshr_idx_t'(s);
    end
  end

  // issue from the head while it has not been accepted
  assign head_entry       = queue[head];
  assign issue_ready      = head_entry.valid && (head_entry.state == waiting);
  assign proc2mem_command = issue_ready ? head_entry.cmd : bus_none;
  assign proc2mem_addr    = head_entry.addr;
  assign proc2mem_data    = head_entry.data;
  assign accept           = issue_ready && (mem2proc_response != '0);

  // writeback side
  assign wb_entry     = queue[wb_head];
  assign fill_valid   = wb_entry.valid && (wb_entry.state == done) && (wb_entry.cmd == bus_load);
  assign fill.addr    = wb_entry.addr;
  assign fill.data    = wb_entry.data;
  assign store_retire = wb_entry.valid && (wb_entry.state == done) &&
                        (wb_entry.cmd == bus_store);
  assign retire       = (fill_valid && stored) || store_retire;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < mshr_depth; i++) begin
        queue[i].valid <= 1'b0;
        queue[i].state <= waiting;
      end
      tail    <= '0;
      head    <= '0;
      wb_head <= '0;
    end else begin
      // tag match on every outstanding load
      for (int i = 0; i < mshr_depth; i++) begin
        if (queue[i].valid && (queue[i].state == in_progress) &&
            (mem2proc_tag != '0) && (queue[i].mem_tag == mem2proc_tag)) begin
          queue[i].state <= done;
          queue[i].data  <= mem2proc_data;
        end
      end

      if (accept) begin
        if (head_entry.cmd == bus_load) begin
          queue[head].mem_tag <= mem2proc_response;
          queue[head].state   <= in_progress;
        end else begin
          // a store is finished once memory takes it
          queue[head].state <= done;
        end
        head <= head + 1'b1;
      end

      if (retire) begin
        queue[wb_head].valid <= 1'b0;
        wb_head              <= wb_head + 1'b1;
      end

      // slots beyond alloc_count are left alone
      if (do_alloc) begin
        for (int s = 0; s < num_miss_ports; s++) begin
          if (s < alloc_count) begin
            queue[alloc_idx[s]].valid   <= 1'b1;
            queue[alloc_idx[s]].state   <= waiting;
            queue[alloc_idx[s]].cmd     <= slot_req[s].cmd;
            queue[alloc_idx[s]].addr    <= slot_req[s].addr;
            queue[alloc_idx[s]].data    <= slot_req[s].data;
            queue[alloc_idx[s]].mem_tag <= '0;
          end
        end
        tail <= tail + mshr_idx_t'(alloc_count);
      end
    end
  end

  // present the array oldest first, starting at the writeback head
  always_comb begin
    for (int k = 0; k < mshr_depth; k++) begin
      entries[k] = queue[mshr_idx_t'(wb_head + mshr_idx_t'(k))];
    end
  end

endmodule

`default_nettype wire

// ==== mshr/mshr_search.sv ====
`timescale 1ns/1ps
`default_nettype none

module mshr_search (
  input  mshr_pkg::mshr_entry_t [mshr_pkg::mshr_depth-1:0]     entries,
  input  mshr_pkg::line_addr_t [mshr_pkg::num_search_ports-1:0] search_addr,
  output logic [mshr_pkg::num_search_ports-1:0]               fwd_valid,
  output mshr_pkg::block_t [mshr_pkg::num_search_ports-1:0]     fwd_data,
  output logic [mshr_pkg::num_search_ports-1:0]               in_flight
);

  import mshr_pkg::*;

  // entries arrive oldest first, so later matches are younger
  always_comb begin
    for (int p = 0; p < num_search_ports; p++) begin
      fwd_valid[p] = 1'b0;
      fwd_data[p]  = '0;
      in_flight[p] = 1'b0;

      for (int k = 0; k < mshr_depth; k++) begin
        if (entries[k].valid && (entries[k].addr == search_addr[p])) begin
          if (entries[k].cmd == bus_store) begin
            fwd_valid[p] = 1'b1;
            fwd_data[p]  = entries[k].data;
            // an older load is shadowed by this store
            in_flight[p] = 1'b0;
          end else if (entries[k].cmd == bus_load) begin
            in_flight[p] = 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mshr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mshr_top (
  input  logic                                                 clock,
  input  logic                                                 reset,
  input  mshr_pkg::miss_req_t [mshr_pkg::num_miss_ports-1:0]   miss,
  output logic                                                 full,
  output mshr_pkg::bus_cmd_e                                   proc2mem_command,
  output mshr_pkg::line_addr_t                                 proc2mem_addr,
  output mshr_pkg::block_t                                     proc2mem_data,
  input  mshr_pkg::mem_tag_t                                   mem2proc_response,
  input  mshr_pkg::mem_tag_t                                   mem2proc_tag,
  input  mshr_pkg::block_t                                     mem2proc_data,
  output logic                                                 fill_valid,
  output mshr_pkg::fill_t                                      fill,
  input  logic                                                 stored,
  input  mshr_pkg::line_addr_t [mshr_pkg::num_search_ports-1:0] search_addr,
  output logic [mshr_pkg::num_search_ports-1:0]               fwd_valid,
  output mshr_pkg::block_t [mshr_pkg::num_search_ports-1:0]     fwd_data,
  output logic [mshr_pkg::num_search_ports-1:0]               in_flight
);

  import mshr_pkg::*;

  miss_req_t [num_miss_ports-1:0] slot_req;
  logic [1:0]                     alloc_count;
  mshr_entry_t [mshr_depth-1:0]   entries;

  mshr_alloc_select u_alloc_select (
    .miss        (miss),
    .slot_req    (slot_req),
    .alloc_count (alloc_count)
  );

  mshr_queue u_queue (
    .clock             (clock),
    .reset             (reset),
    .slot_req          (slot_req),
    .alloc_count       (alloc_count),
    .full              (full),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .fill_valid        (fill_valid),
    .fill              (fill),
    .stored            (stored),
    .entries           (entries)
  );

  mshr_search u_search (
    .entries     (entries),
    .search_addr (search_addr),
    .fwd_valid   (fwd_valid),
    .fwd_data    (fwd_data),
    .in_flight   (in_flight)
  );

endmodule

`default_nettype wire

// ==== test/mshr_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mshr_tb;

  import mshr_pkg::*;

  localparam int wait_limit = 400;

  logic                              clock;
  logic                              reset;
  miss_req_t [num_miss_ports-1:0]    miss;
  logic                              full;
  bus_cmd_e                          proc2mem_command;
  line_addr_t                        proc2mem_addr;
  block_t                            proc2mem_data;
  mem_tag_t                          mem2proc_response = '0;
  mem_tag_t                          mem2proc_tag = '0;
  block_t                            mem2proc_data = '0;
  logic                              fill_valid;
  fill_t                             fill;
  logic                              stored = 1'b0;
  line_addr_t [num_search_ports-1:0] search_addr;
  logic [num_search_ports-1:0]       fwd_valid;
  block_t [num_search_ports-1:0]     fwd_data;
  logic [num_search_ports-1:0]       in_flight;

  // reply data per line as listed by the L lines
  block_t load_data [line_addr_t];
  fill_t  fill_q [$];
  fill_t  store_q [$];

  // loads accepted by the memory model and not yet answered
  mem_tag_t   reply_tag [$];
  line_addr_t reply_addr [$];
  int         reply_delay [$];

  miss_req_t [num_miss_ports-1:0] group;
  logic        mem_hold;
  mem_tag_t    next_tag = 4'd1;
  int          ready_idx;
  logic        stored_pending = 1'b0;
  int          stored_delay = 0;
  int          mismatch_count = 0;
  int          other_count = 0;

  mshr_top UUT (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    other_count++;
    $display("%0t: %s", $time, msg);
  endtask

  function automatic block_t line_data(input line_addr_t addr);
    return load_data.exists(addr) ? load_data[addr] : '0;
  endfunction

  // memory model that accepts at the edge and answers loads after a random delay
  always @(posedge clock) begin
    if (reset) begin
      mem2proc_response <= '0;
      mem2proc_tag      <= '0;
      next_tag = 4'd1;
    end else begin
      ready_idx = -1;
      for (int i = 0; i < reply_delay.size(); i++) begin
        if (reply_delay[i] > 0) begin
          reply_delay[i]--;
        end
        if (reply_delay[i] == 0 && ready_idx < 0) begin
          ready_idx = i;
        end
      end
      // one reply per cycle
      mem2proc_tag <= '0;
      if (ready_idx >= 0) begin
        mem2proc_tag  <= reply_tag[ready_idx];
        mem2proc_data <= line_data(reply_addr[ready_idx]);
        reply_tag.delete(ready_idx);
        reply_addr.delete(ready_idx);
        reply_delay.delete(ready_idx);
      end
      if (proc2mem_command != bus_none && mem2proc_response != '0) begin
        if (proc2mem_command == bus_load) begin
          reply_tag.push_back(mem2proc_response);
          reply_addr.push_back(proc2mem_addr);
          reply_delay.push_back(1 + int'($urandom % 6));
        end else begin
          $display("%0t: memory store addr %h data %h", $time, proc2mem_addr,
                   proc2mem_data);
          if (store_q.size() == 0) begin
            report_failure("memory received a store that was never requested");
          end else begin
            check_value("store addr", 64'(proc2mem_addr), 64'(store_q[0].addr));
            check_value("store data", proc2mem_data, store_q[0].data);
            void'(store_q.pop_front());
          end
        end
        next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
      mem2proc_response <= mem_hold ? '0 : next_tag;
    end
  end

  // fill scoreboard and the stored pulse
  always @(posedge clock) begin
    if (reset) begin
      stored <= 1'b0;
      stored_pending = 1'b0;
    end else if (stored) begin
      stored <= 1'b0;
      stored_pending = 1'b0;
    end else if (stored_pending) begin
      stored_delay--;
      if (stored_delay == 0) begin
        stored <= 1'b1;
      end
    end else if (fill_valid) begin
      if (fill_q.size() == 0) begin
        report_failure("fill came out with no load outstanding");
      end else begin
        check_value("fill addr", 64'(fill.addr), 64'(fill_q[0].addr));
        check_value("fill data", fill.data, fill_q[0].data);
        void'(fill_q.pop_front());
      end
      stored_delay   = 1 + int'($urandom % 3);
      stored_pending = 1'b1;
    end
  end

  // present the collected miss ports for one cycle, then idle one cycle
  task automatic flush_misses();
    int    waited;
    logic  any;
    fill_t expect_entry;
    any = 1'b0;
    for (int p = 0; p < num_miss_ports; p++) begin
      any = any | group[p].valid;
    end
    if (any) begin
      waited = 0;
      @(posedge clock);
      while (full && waited < wait_limit) begin
        @(posedge clock);
        waited++;
      end
      if (full) begin
        report_failure("timed out waiting for full to drop before a miss");
      end else begin
        miss <= group;
        // allocation follows port order
        for (int p = 0; p < num_miss_ports; p++) begin
          expect_entry.addr = group[p].addr;
          expect_entry.data = group[p].data;
          if (group[p].valid && group[p].cmd == bus_load) begin
            expect_entry.data = line_data(group[p].addr);
            fill_q.push_back(expect_entry);
          end else if (group[p].valid) begin
            store_q.push_back(expect_entry);
          end
        end
        @(posedge clock);
        miss <= '0;
      end
      group = '0;
    end
  endtask

  task automatic add_miss(input int port, input logic [63:0] cmd,
                          input logic [63:0] addr, input logic [63:0] data);
    if (group[port].valid) begin
      flush_misses();
    end
    group[port].valid = 1'b1;
    group[port].cmd   = bus_cmd_e'(cmd[1:0]);
    group[port].addr  = line_addr_t'(addr);
    group[port].data  = data;
  endtask

  task automatic drain_queue();
    int waited;
    waited = 0;
    @(posedge clock);
    while ((fill_q.size() != 0 || store_q.size() != 0 || reply_tag.size() != 0 ||
            fill_valid || stored_pending || proc2mem_command != bus_none) &&
           waited < wait_limit) begin
      @(posedge clock);
      waited++;
    end
    if (waited >= wait_limit) begin
      report_failure("timed out waiting for the MSHR to drain");
    end
  endtask

  task automatic set_hold(input logic on, input logic exp_full);
    if (on) begin
      drain_queue();
    end
    @(posedge clock);
    check_value("full", 64'(full), 64'(exp_full));
    mem_hold <= on;
  endtask

  task automatic run_search(input int port, input logic [63:0] addr,
                            input logic [63:0] exp_fwd, input logic [63:0] exp_in_flight,
                            input logic [63:0] exp_data);
    @(posedge clock);
    search_addr[port] <= line_addr_t'(addr);
    @(posedge clock);
    check_value("fwd_valid", 64'(fwd_valid[port]), exp_fwd);
    check_value("in_flight", 64'(in_flight[port]), exp_in_flight);
    if (exp_fwd != 0) begin
      check_value("fwd_data", fwd_data[port], exp_data);
    end
  endtask

  initial begin
    int          fd;
    string       line;
    byte         kind;
    logic        ended;
    logic [63:0] f1, f2, f3, f4, f5;
    void'($urandom(32'h3f67));
    reset       = 1'b1;
    miss        = '0;
    search_addr = '0;
    mem_hold    = 1'b0;
    group       = '0;
    ended       = 1'b0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    check_value("command after reset", 64'(proc2mem_command), 64'(bus_none));
    check_value("fill_valid after reset", 64'(fill_valid), 64'(0));
    check_value("full after reset", 64'(full), 64'(0));

    fd = $fopen("test/mshr_stimulus.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open test/mshr_stimulus.txt");
    end else begin
      while (!ended && $fgets(line, fd) != 0) begin
        kind = (line.len() > 0) ? line.getc(0) : 8'h23;
        f1 = '0;
        f2 = '0;
        f3 = '0;
        f4 = '0;
        f5 = '0;
        if (line.len() > 1) begin
          void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                        f1, f2, f3, f4, f5));
        end
        case (kind)
          "M": add_miss(int'(f1[0]), f2, f3, f4);
          "L": load_data[line_addr_t'(f1)] = f2;
          "H": begin
            flush_misses();
            set_hold(f1[0], f2[0]);
          end
          "S": begin
            flush_misses();
            run_search(int'(f1[0]), f2, f3, f4, f5);
          end
          "E": begin
            flush_misses();
            ended = 1'b1;
          end
          default: ;
        endcase
      end
      $fclose(fd);
      if (!ended) begin
        report_failure("stimulus file ended without an E line");
      end
      drain_queue();
      @(posedge clock);
      check_value("full at end", 64'(full), 64'(0));
      check_value("fill_valid at end", 64'(fill_valid), 64'(0));
      check_value("command at end", 64'(proc2mem_command), 64'(bus_none));
    end

    $display("errors: %0d value mismatches, %0d other failures", mismatch_count,
             other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/mshr_stimulus.txt ====
# M port cmd(1 load, 2 store) line_addr data | L line_addr reply_data | H hold expected_full
# S port line_addr fwd_valid in_flight fwd_data | E end of run
L 0000100 a1a1a1a100000100
L 0000101 b2b2b2b200000101
L 0000102 c3c3c3c300000102
L 0000103 d4d4d4d400000103
L 0000200 e5e5e5e500000200
L 0000201 f6f6f6f600000201
L 0000202 0707070700000202
M 0 1 0000100 0
M 1 1 0000101 0
M 0 1 0000102 0
M 1 2 0000300 5555000000000300
M 0 1 0000103 0
M 0 2 0000301 6666000000000301
H 1 0
M 0 2 0000400 7777000000000400
M 1 1 0000200 0
M 0 2 0000400 8888000000000400
M 1 1 0000201 0
M 0 2 0000401 9999000000000401
M 1 2 0000402 aaaa000000000402
M 0 1 0000202 0
M 1 2 0000201 bbbb000000000201
S 0 0000400 1 0 8888000000000400
S 1 0000200 0 1 0
S 0 0000201 1 0 bbbb000000000201
S 1 0000500 0 0 0
S 0 0000202 0 1 0
H 0 1
M 0 1 0000102 0
M 1 2 0000600 cccc000000000600
E

// ==== cache_mshr.f ====
common/mshr_pkg.sv
mshr/mshr_alloc_select.sv
mshr/mshr_queue.sv
mshr/mshr_search.sv
hdl/mshr_top.sv
test/mshr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the MSHR testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f cache_mshr.f --top-module mshr_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vmshr_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF "*** PASSED ***" "$LOG"; then
  exit 0
fi
exit 1
